// File: filelist.f
logic/bip1Pkg.sv
logic/instructionDecoder.sv
logic/programCounter.sv
logic/programMemory.sv
logic/dataMemory.sv
logic/accumulatorPath.sv
logic/bip1Cpu.sv
verification/bip1CpuTb.sv

// File: logic/accumulatorPath.sv
`timescale 1ns/1ns

module accumulatorPath
    import bip1Pkg::*;
(
    input  logic                 clk,
    input  logic                 arstN,
    input  instrT                instr,
    input  ctrlT                 ctrl,
    input  logic [wordWidth-1:0] memData,
    output logic [wordWidth-1:0] acc
);

    logic [wordWidth-1:0] immExt;               // Sign-extended operand
    logic [wordWidth-1:0] operandB;             // ALU second input
    logic [wordWidth-1:0] aluResult;            // Sum or difference
    logic [wordWidth-1:0] accNext;              // Accumulator input

    ////////////////////////////////////////////////////////////
    // Operand preparation
    ////////////////////////////////////////////////////////////
    assign immExt = {{(wordWidth - immWidth){instr.asImm.imm[immWidth-1]}},
                     instr.asImm.imm};          // Replicate the sign bit

    always_comb
    begin
        if (ctrl.selB == selBImm)
        begin
            operandB = immExt;                  // Immediate instructions
        end
        else
        begin
            operandB = memData;                 // Variable instructions
        end
    end

    ////////////////////////////////////////////////////////////
    // ALU
    ////////////////////////////////////////////////////////////
    always_comb
    begin
        if (ctrl.op == opSub)
        begin
            aluResult = acc - operandB;         // Modulo 2^16
        end
        else
        begin
            aluResult = acc + operandB;         // Carry out is dropped
        end
    end

    ////////////////////////////////////////////////////////////
    // Accumulator source and register
    ////////////////////////////////////////////////////////////
    always_comb
    begin
        case (ctrl.selA)
            selAMem:
            begin
                accNext = memData;              // Load variable
            end
            selAImm:
            begin
                accNext = immExt;               // Load immediate
            end
            selAAlu:
            begin
                accNext = aluResult;            // Arithmetic
            end
            default:
            begin
                accNext = acc;                  // Unused code keeps the value
            end
        endcase
    end

    always_ff @(posedge clk or negedge arstN)
    begin
        if (!arstN)
        begin
            acc <= '0;
        end
        else if (ctrl.wrAcc)
        begin
            acc <= accNext;                     // Result lands one cycle after fetch
        end
    end

endmodule

// File: logic/bip1Cpu.sv
`timescale 1ns/1ns

module bip1Cpu
    import bip1Pkg::*;
(
    input  logic                 clk,
    input  logic                 arstN,
    input  logic                 run,
    input  logic                 progWe,
    input  logic [pcWidth-1:0]   progAddr,
    input  instrT                progData,
    output logic [pcWidth-1:0]   pc,
    output logic [wordWidth-1:0] acc,
    output logic                 halted
);

    instrT                instr;                // Fetched word
    ctrlT                 ctrl;                 // Decoded control
    logic [wordWidth-1:0] memData;              // Gated data memory output

    ////////////////////////////////////////////////////////////
    // Fetch and decode
    ////////////////////////////////////////////////////////////
    programMemory progMemInst (
        .clk      (clk),
        .progWe   (progWe),
        .progAddr (progAddr),
        .progData (progData),
        .pc       (pc),
        .instr    (instr)
    );

    instructionDecoder decoderInst (
        .opcode (instr.asVar.opcode),           // Both views share the opcode
        .run    (run),
        .ctrl   (ctrl),
        .halted (halted)
    );

    programCounter pcInst (
        .clk   (clk),
        .arstN (arstN),
        .ctrl  (ctrl),
        .pc    (pc)
    );

    ////////////////////////////////////////////////////////////
    // Execute
    ////////////////////////////////////////////////////////////
    dataMemory dataMemInst (
        .clk    (clk),
        .instr  (instr),
        .ctrl   (ctrl),
        .wrData (acc),                          // Store writes the accumulator
        .rdData (memData)
    );

    accumulatorPath accPathInst (
        .clk     (clk),
        .arstN   (arstN),
        .instr   (instr),
        .ctrl    (ctrl),
        .memData (memData),
        .acc     (acc)
    );

endmodule

// File: logic/bip1Pkg.sv
package bip1Pkg;

    ////////////////////////////////////////////////////////////
    // Word and memory sizes
    ////////////////////////////////////////////////////////////
    localparam int opcodeWidth = 3;             // Eight instructions in the ISA
    localparam int wordWidth   = 16;            // Instruction and data word
    localparam int addrWidth   = 12;            // Direct data address field
    localparam int immWidth    = 13;            // Signed immediate field
    localparam int pcWidth     = 10;            // 1024 program words
    localparam int dataDepth   = 4096;          // Data memory words

    ////////////////////////////////////////////////////////////
    // Opcodes and datapath select codes
    ////////////////////////////////////////////////////////////
    localparam logic [opcodeWidth-1:0] opHalt     = 3'd0;  // Stop fetching
    localparam logic [opcodeWidth-1:0] opStoreVar = 3'd1;  // DM[addr] <= ACC
    localparam logic [opcodeWidth-1:0] opLoadVar  = 3'd2;  // ACC <= DM[addr]
    localparam logic [opcodeWidth-1:0] opLoadImm  = 3'd3;  // ACC <= imm
    localparam logic [opcodeWidth-1:0] opAddVar   = 3'd4;  // ACC <= ACC + DM[addr]
    localparam logic [opcodeWidth-1:0] opAddImm   = 3'd5;  // ACC <= ACC + imm
    localparam logic [opcodeWidth-1:0] opSubVar   = 3'd6;  // ACC <= ACC - DM[addr]
    localparam logic [opcodeWidth-1:0] opSubImm   = 3'd7;  // ACC <= ACC - imm

    localparam logic [1:0] selAMem = 2'd0;      // Accumulator takes memory data
    localparam logic [1:0] selAImm = 2'd1;      // Accumulator takes extended immediate
    localparam logic [1:0] selAAlu = 2'd2;      // Accumulator takes ALU result

    localparam logic selBMem = 1'b0;            // ALU operand from data memory
    localparam logic selBImm = 1'b1;            // ALU operand from immediate

    localparam logic opAdd = 1'b0;
    localparam logic opSub = 1'b1;

    ////////////////////////////////////////////////////////////
    // Instruction word and control word
    ////////////////////////////////////////////////////////////
    typedef struct packed {
        logic [opcodeWidth-1:0] opcode;
        logic                   spare;          // Ignored by the core
        logic [addrWidth-1:0]   addr;
    } varInstrT;

    typedef struct packed {
        logic [opcodeWidth-1:0]    opcode;
        logic signed [immWidth-1:0] imm;
    } immInstrT;

    typedef union packed {
        varInstrT asVar;                        // Memory operand view
        immInstrT asImm;                        // Immediate operand view
    } instrT;

    typedef struct packed {
        logic       wrPc;                       // Advance the program counter
        logic [1:0] selA;                       // Accumulator source
        logic       selB;                       // ALU second operand
        logic       wrAcc;                      // Load the accumulator
        logic       op;                         // Add or subtract
        logic       wrRam;                      // Write data memory
        logic       rdRam;                      // Read data memory
    } ctrlT;

endpackage

// File: logic/dataMemory.sv
`timescale 1ns/1ns

module dataMemory
    import bip1Pkg::*;
(
    input  logic                 clk,
    input  instrT                instr,
    input  ctrlT                 ctrl,
    input  logic [wordWidth-1:0] wrData,
    output logic [wordWidth-1:0] rdData
);

    logic [wordWidth-1:0] mem [dataDepth];      // Variable store
    logic [addrWidth-1:0] addr;                 // Direct operand address

    assign addr = instr.asVar.addr;             // Variable view of the word

    always_ff @(posedge clk)
    begin
        if (ctrl.wrRam)
        begin
            mem[addr] <= wrData;                // Visible to the next instruction
        end
    end

    // Read data only while the decoder asks for it
    assign rdData = ctrl.rdRam ? mem[addr] : '0;

endmodule

// File: logic/instructionDecoder.sv
`timescale 1ns/1ns

module instructionDecoder
    import bip1Pkg::*;
(
    input  logic [opcodeWidth-1:0] opcode,
    input  logic                   run,
    output ctrlT                   ctrl,
    output logic                   halted
);

    always_comb
    begin
        ctrl   = '0;                            // Idle word while loading or halted
        halted = 1'b0;
        if (run)
        begin
            case (opcode)
                opHalt:
                begin
                    halted = 1'b1;              // PC stops counting
                end
                opStoreVar:
                begin
                    ctrl.wrPc  = 1'b1;
                    ctrl.wrRam = 1'b1;          // ACC goes to DM and stays put
                end
                opLoadVar:
                begin
                    ctrl.wrPc  = 1'b1;
                    ctrl.selA  = selAMem;       // DM output into ACC
                    ctrl.wrAcc = 1'b1;
                    ctrl.rdRam = 1'b1;
                end
                opLoadImm:
                begin
                    ctrl.wrPc  = 1'b1;
                    ctrl.selA  = selAImm;       // Extended operand into ACC
                    ctrl.wrAcc = 1'b1;
                end
                opAddVar:
                begin
                    ctrl.wrPc  = 1'b1;
                    ctrl.selA  = selAAlu;
                    ctrl.selB  = selBMem;       // Second addend from DM
                    ctrl.wrAcc = 1'b1;
                    ctrl.op    = opAdd;
                    ctrl.rdRam = 1'b1;
                end
                opAddImm:
                begin
                    ctrl.wrPc  = 1'b1;
                    ctrl.selA  = selAAlu;
                    ctrl.selB  = selBImm;       // Second addend is the operand
                    ctrl.wrAcc = 1'b1;
                    ctrl.op    = opAdd;
                end
                opSubVar:
                begin
                    ctrl.wrPc  = 1'b1;
                    ctrl.selA  = selAAlu;
                    ctrl.selB  = selBMem;       // Subtrahend from DM
                    ctrl.wrAcc = 1'b1;
                    ctrl.op    = opSub;
                    ctrl.rdRam = 1'b1;
                end
                opSubImm:
                begin
                    ctrl.wrPc  = 1'b1;
                    ctrl.selA  = selAAlu;
                    ctrl.selB  = selBImm;       // Subtrahend is the operand
                    ctrl.wrAcc = 1'b1;
                    ctrl.op    = opSub;
                end
            endcase
        end
    end

endmodule

// File: logic/programCounter.sv
`timescale 1ns/1ns

module programCounter
    import bip1Pkg::*;
(
    input  logic               clk,
    input  logic               arstN,
    input  ctrlT               ctrl,
    output logic [pcWidth-1:0] pc
);

    // Next fetch address
    logic [pcWidth-1:0] pcNext;

    assign pcNext = pc + 1'b1;                  // Rolls over after the last word

    always_ff @(posedge clk or negedge arstN)
    begin
        if (!arstN)
        begin
            pc <= '0;                           // Fetch starts at word zero
        end
        else if (ctrl.wrPc)
        begin
            pc <= pcNext;                       // One step per executed instruction
        end
    end

endmodule

// File: logic/programMemory.sv
`timescale 1ns/1ns

module programMemory
    import bip1Pkg::*;
(
    input  logic               clk,
    input  logic               progWe,
    input  logic [pcWidth-1:0] progAddr,
    input  instrT              progData,
    input  logic [pcWidth-1:0] pc,
    output instrT              instr
);

    instrT mem [2**pcWidth];                    // Program store

    ////////////////////////////////////////////////////////////
    // Load port
    ////////////////////////////////////////////////////////////
    always_ff @(posedge clk)
    begin
        if (progWe)
        begin
            mem[progAddr] <= progData;          // Accepted with or without run
        end
    end

    ////////////////////////////////////////////////////////////
    // Fetch port
    ////////////////////////////////////////////////////////////
    assign instr = mem[pc];                     // Same cycle as the PC

endmodule

// File: verification/bip1CpuTb.sv
`timescale 1ns/1ns

module bip1CpuTb
    import bip1Pkg::*;
;

    localparam int clkPeriod   = 40;
    localparam int driveDelay  = 5;             // Inputs change after the rising edge
    localparam int resetCycles = 4;
    localparam int haltLimit   = 2000;          // Cap on every wait for halted
    localparam int holdCycles  = 20;

    logic                 clk;
    logic                 arstN;
    logic                 run;
    logic                 progWe;
    logic [pcWidth-1:0]   progAddr;
    instrT                progData;
    logic [pcWidth-1:0]   pc;
    logic [wordWidth-1:0] acc;
    logic                 halted;

    logic [wordWidth-1:0] modelProg [2**pcWidth];   // Copy of the loaded program
    logic [wordWidth-1:0] modelData [dataDepth];    // Reference data store
    logic [pcWidth-1:0]   modelPc;
    logic [wordWidth-1:0] modelAcc;

    logic [wordWidth-1:0] progWords [$];        // Program under construction
    logic [addrWidth-1:0] varAddr [4];          // Addresses used by the memory tests
    logic [15:0]          lfsrState;
    string                testName;
    int                   errorCount = 0;

    bip1Cpu UUT (
        .clk      (clk),
        .arstN    (arstN),
        .run      (run),
        .progWe   (progWe),
        .progAddr (progAddr),
        .progData (progData),
        .pc       (pc),
        .acc      (acc),
        .halted   (halted)
    );

    initial
    begin
        clk = 1'b0;
        forever #(clkPeriod / 2) clk = ~clk;
    end

    ////////////////////////////////////////////////////////////
    // Reference model, one instruction per executed edge
    ////////////////////////////////////////////////////////////
    always @(posedge clk or negedge arstN)
    begin : modelStep
        logic [wordWidth-1:0] word;
        logic [wordWidth-1:0] imm;
        logic [addrWidth-1:0] adr;
        if (!arstN)
        begin
            modelPc  <= '0;
            modelAcc <= '0;
        end
        else if (run)
        begin
            word = modelProg[modelPc];
            adr  = word[11:0];                  // Direct address field
            imm  = {{3{word[12]}}, word[12:0]}; // 13-bit signed operand
            if (word[15:13] != opHalt)
            begin
                modelPc <= modelPc + 1'b1;
            end
            case (word[15:13])
                opStoreVar: modelData[adr] <= modelAcc;
                opLoadVar:  modelAcc <= modelData[adr];
                opLoadImm:  modelAcc <= imm;
                opAddVar:   modelAcc <= modelAcc + modelData[adr];
                opAddImm:   modelAcc <= modelAcc + imm;
                opSubVar:   modelAcc <= modelAcc - modelData[adr];
                opSubImm:   modelAcc <= modelAcc - imm;
                default:    modelAcc <= modelAcc;   // Halt holds everything
            endcase
        end
    end

    // Compare in the middle of the cycle where all outputs have settled
    always @(negedge clk)
    begin : compareModel
        logic expHalted;
        expHalted = run && (modelProg[modelPc][15:13] === opHalt);
        assert (pc === modelPc) else
        begin
            $display("** Error [%s] pc: expected %0d, actual %0d", testName, modelPc, pc);
            errorCount++;
        end
        assert (acc === modelAcc) else
        begin
            $display("** Error [%s] acc: expected %h, actual %h", testName, modelAcc, acc);
            errorCount++;
        end
        assert (halted === expHalted) else
        begin
            $display("** Error [%s] halted: expected %b, actual %b", testName, expHalted,
                     halted);
            errorCount++;
        end
    end

    ////////////////////////////////////////////////////////////
    // Helpers
    ////////////////////////////////////////////////////////////
    function automatic logic [15:0] lfsrNext(input logic [15:0] s);
        lfsrNext = s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);    // x^16+x^14+x^13+x^11+1
    endfunction

    task automatic drawBits(input int count, output logic [15:0] value);
        int i;
        value = '0;
        for (i = 0; i < count; i++)
        begin
            value     = {value[14:0], lfsrState[0]};  // One step per bit
            lfsrState = lfsrNext(lfsrState);
        end
    endtask

    task automatic emitImm(input logic [2:0] op, input logic [12:0] imm);
        progWords.push_back({op, imm});
    endtask

    task automatic emitVar(input logic [2:0] op, input logic [11:0] adr);
        progWords.push_back({op, 1'b0, adr});   // Spare bit left clear
    endtask

    task automatic finishRun();
        $display("Simulation finished with %0d errors", errorCount);
        if (errorCount == 0)
        begin
            $display("All tests passed!");
        end
        else
        begin
            $display("Test failures found");
        end
        $finish;
    endtask

    task automatic resetCore();
        @(posedge clk);
        #driveDelay;
        run   = 1'b0;
        arstN = 1'b0;
        repeat (resetCycles) @(posedge clk);
        #driveDelay;
        arstN = 1'b1;
        assert (pc === '0) else
        begin
            $display("** Error [%s] pc after reset: expected 0, actual %0d", testName, pc);
            errorCount++;
        end
        assert (acc === '0) else
        begin
            $display("** Error [%s] acc after reset: expected 0000, actual %h", testName, acc);
            errorCount++;
        end
    endtask

    task automatic loadProgram();
        int i;
        for (i = 0; i < progWords.size(); i++)
        begin
            @(posedge clk);
            #driveDelay;
            assert (pc === '0) else
            begin
                $display("** Error [%s] pc during load: expected 0, actual %0d", testName, pc);
                errorCount++;
            end
            progWe       = 1'b1;
            progAddr     = i[pcWidth-1:0];
            progData     = progWords[i];
            modelProg[i] = progWords[i];
        end
        @(posedge clk);
        #driveDelay;
        progWe = 1'b0;
        run    = 1'b1;                          // Core starts at the next edge
    endtask

    task automatic waitForHalt();
        int cycles;
        cycles = 0;
        while (halted !== 1'b1 && cycles < haltLimit)
        begin
            @(negedge clk);
            cycles++;
        end
        if (halted !== 1'b1)
        begin
            $display("Program of test %s did not halt within %0d cycles", testName, haltLimit);
            errorCount++;
        end
    endtask

    task automatic checkHaltHold();
        logic [pcWidth-1:0]   pcHeld;
        logic [wordWidth-1:0] accHeld;
        int i;
        pcHeld  = modelPc;                      // State of the model at the halt
        accHeld = modelAcc;
        for (i = 0; i < holdCycles; i++)
        begin
            @(negedge clk);
            assert (pc === pcHeld && acc === accHeld && halted === 1'b1) else
            begin
                $display("** Error [%s] halt hold: expected pc %0d acc %h, actual pc %0d acc %h",
                         testName, pcHeld, accHeld, pc, acc);
                errorCount++;
            end
        end
    endtask

    task automatic runProgram(input string name);
        testName = name;
        loadProgram();
        waitForHalt();
        if (halted === 1'b1)
        begin
            checkHaltHold();
        end
    endtask

    ////////////////////////////////////////////////////////////
    // Test sequence
    ////////////////////////////////////////////////////////////
    initial
    begin
        logic [15:0] value;
        int i;
        arstN     = 1'b0;
        run       = 1'b0;
        progWe    = 1'b0;
        progAddr  = '0;
        progData  = '0;
        lfsrState = 16'd6;
        testName  = "reset";
        repeat (resetCycles) @(posedge clk);
        #driveDelay;
        arstN = 1'b1;
        repeat (3) @(posedge clk);              // Idle with run low

        progWords.delete();
        for (i = 0; i < 12; i++)
        begin
            drawBits(12, value);
            emitImm(opLoadImm, {i[0], value[11:0]});   // Sign alternates
        end
        emitImm(opHalt, '0);
        runProgram("loadImm");

        testName = "addSubImm";
        resetCore();
        progWords.delete();
        emitImm(opLoadImm, 13'h1FFF);           // Minus one
        emitImm(opAddImm, 13'd1);               // Wraps up to zero
        emitImm(opSubImm, 13'd1);               // Wraps down to FFFF
        for (i = 0; i < 20; i++)
        begin
            drawBits(14, value);
            emitImm(value[13] ? opSubImm : opAddImm, value[12:0]);
        end
        emitImm(opHalt, '0);
        runProgram("addSubImm");

        testName = "memory";
        resetCore();
        progWords.delete();
        varAddr[0] = 12'h000;
        varAddr[1] = 12'hFFF;
        drawBits(12, value);
        varAddr[2] = value[11:0];
        drawBits(12, value);
        varAddr[3] = value[11:0];
        for (i = 0; i < 4; i++)
        begin
            drawBits(13, value);
            emitImm(opLoadImm, value[12:0]);
            emitVar(opStoreVar, varAddr[i]);
            emitVar(opLoadVar, varAddr[i]);     // Load right behind the store
        end
        emitVar(opLoadVar, varAddr[0]);
        emitVar(opAddVar, varAddr[1]);
        emitVar(opSubVar, varAddr[2]);
        emitVar(opAddVar, varAddr[3]);
        emitVar(opSubVar, varAddr[1]);
        emitImm(opHalt, '0);
        runProgram("memory");

        testName = "halt";
        resetCore();
        progWords.delete();
        drawBits(13, value);
        emitImm(opLoadImm, value[12:0]);
        emitImm(opAddImm, 13'd7);
        emitImm(opHalt, '0);
        emitImm(opAddImm, 13'd5);               // Never reached
        runProgram("halt");

        testName = "rerun";
        resetCore();
        progWords.delete();
        emitVar(opLoadVar, varAddr[1]);         // Written by the memory test
        emitVar(opAddVar, varAddr[2]);
        emitImm(opHalt, '0);
        runProgram("rerun");

        finishRun();
    end

endmodule
